/* Bender.yml */
package:
  name: uart_bridge

sources:
  - source/uart_pkg.sv
  - source/frame_pkg.sv
  - source/rx_byte_if.sv
  - source/uart_rx.sv
  - source/uart_tx.sv
  - source/rx_frame_assembler.sv
  - source/tx_frame_sender.sv
  - source/uart_bridge.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_uart_bridge.sv

/* bench/tb_serial_model.svh */
`ifndef TB_SERIAL_MODEL_SVH
`define TB_SERIAL_MODEL_SVH

// Drives one frame onto rx: start bit, eight data bits LSB first, then the stop bit.
task automatic send_byte(input logic [7:0] value, input logic stop_level);
    int i;
    @(posedge clk);
    rx <= 1'b0;
    for (i = 0; i < 8; i++) begin
        repeat (bit_cycles) @(posedge clk);
        rx <= value[i];
    end
    repeat (bit_cycles) @(posedge clk);
    rx <= stop_level;
    repeat (bit_cycles) @(posedge clk);
    if (!stop_level) begin
        // The receiver needs a quiet line to shake off the bad frame.
        rx <= 1'b1;
        repeat (2 * bit_cycles) @(posedge clk);
    end
endtask

// Waits for a start bit on tx and samples every bit in its middle.
task automatic receive_byte(output logic [7:0] value, output logic stop_level);
    int i;
    wait (tx == 1'b0);
    repeat (bit_cycles / 2) @(posedge clk);
    @(negedge clk);
    check(tx, 1'b0, "tx start bit still low at mid-bit");
    for (i = 0; i < 8; i++) begin
        repeat (bit_cycles) @(negedge clk);
        value[i] = tx;
    end
    repeat (bit_cycles) @(negedge clk);
    stop_level = tx;
endtask

// Receives the bytes first..last of a frame and compares them in order.
task automatic expect_tx_bytes(input byte_q_t bytes, input int first, input int last,
                               input string what);
    logic [7:0] value;
    logic       stop_level;
    int         i;
    for (i = first; i <= last; i++) begin
        receive_byte(value, stop_level);
        check(value, bytes[i], $sformatf("%s byte %0d on tx", what, i));
        check(stop_level, 1'b1, $sformatf("%s stop bit of byte %0d", what, i));
    end
endtask

// The line must stay high for the whole window.
task automatic expect_line_idle(input int cycles);
    int i;
    for (i = 0; i < cycles; i++) begin
        @(negedge clk);
        check(tx, 1'b1, "tx idle level");
    end
endtask

`endif

/* bench/tb_uart_bridge.sv */
`timescale 1ns/100ps

module tb_uart_bridge;
    import uart_pkg::*;

    localparam int clk_period     = 40;
    localparam int bit_cycles     = 25_000_000 / 3_125_000;
    localparam int rx_buffer_bits = 64;
    localparam int tx_buffer_bits = 64;
    localparam int rx_capacity    = rx_buffer_bits / 8 - 3;

    // Eight packets of up to eight bytes with their idle gaps, eight sent bytes, startup.
    localparam int frame_bits  = 8 * 10 + 3 + idle_bits + 2;
    localparam int total_bits  = 8 * frame_bits + 8 * 11 + 60;
    localparam int watchdog_ns = total_bits * bit_cycles * clk_period * 3 / 2;

    typedef logic [7:0] byte_q_t [$];

    logic                      clk;
    logic                      rst;
    logic                      rx;
    logic                      tx;
    logic [rx_buffer_bits-1:0] rx_data;
    logic [tx_buffer_bits-1:0] tx_data;

    logic [31:0]       rng_state = 32'hcac3;
    logic [63:0]       expected_words [$];
    logic [7:0]        expected_ack = 8'd0;
    int                rx_frame_count = 0;
    int                words_seen = 0;

    uart_bridge u_uart_bridge (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .tx      (tx),
        .rx_data (rx_data),
        .tx_data (tx_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    `include "tb_serial_model.svh"

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        state = state ^ (state << 13);
        state = state ^ (state >> 17);
        state = state ^ (state << 5);
        return state;
    endfunction

    task automatic random_bytes(input int n, output byte_q_t bytes);
        int i;
        bytes = {};
        for (i = 0; i < n; i++) begin
            rng_state = xorshift(rng_state);
            bytes.push_back(rng_state[7:0]);
        end
    endtask

    // Status word: ack, frame counter, saturated count, then the payload lowest first.
    function automatic logic [63:0] expected_rx_word(input byte_q_t bytes,
                                                     input logic [7:0] counter,
                                                     input logic [7:0] ack);
        logic [63:0] word;
        int          n;
        int          i;
        word = '0;
        n = (bytes.size() > rx_capacity) ? rx_capacity : bytes.size();
        word[7:0]   = ack;
        word[15:8]  = counter;
        word[23:16] = n[7:0];
        for (i = 0; i < n; i++)
            word[24 + 8 * i +: 8] = bytes[i];
        return word;
    endfunction

    function automatic logic [63:0] tx_word(input logic [7:0] id, input byte_q_t payload);
        logic [63:0] word;
        int          i;
        word = '0;
        word[7:0]  = id;
        word[15:8] = 8'(payload.size() - 1); // Length field is bytes minus one.
        for (i = 0; i < payload.size(); i++)
            word[16 + 8 * i +: 8] = payload[i];
        return word;
    endfunction

    // Sends a packet on rx, the byte at bad_index with a low stop bit, and waits for its word.
    task automatic send_packet(input byte_q_t bytes, input int bad_index);
        byte_q_t good;
        int      i;
        good = {};
        for (i = 0; i < bytes.size(); i++)
            if (i != bad_index)
                good.push_back(bytes[i]);
        expected_words.push_back(expected_rx_word(good, 8'(rx_frame_count), expected_ack));
        for (i = 0; i < bytes.size(); i++)
            send_byte(bytes[i], i != bad_index);
        rx_frame_count++;
        wait (words_seen == rx_frame_count);
    endtask

    // Every update of rx_data must match the next word in line.
    initial begin
        @(negedge rst);
        forever begin
            @(rx_data);
            @(negedge clk);
            if (expected_words.size() == 0) begin
                $display("rx_data changed at %0t ns while no packet was outstanding", $time);
                $display("Testbench failed");
                $fatal(1, "unexpected rx word");
            end else begin
                check(rx_data, expected_words.pop_front(),
                      $sformatf("rx word of frame %0d", words_seen));
                words_seen++;
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("The run timed out after %0d ns without finishing its tests", watchdog_ns);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        byte_q_t    bytes;
        byte_q_t    frame2;
        byte_q_t    frame3;
        int         i;
        rx      = 1'b1;
        rst     = 1'b1;
        tx_data = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check(rx_data, '0, "rx_data after reset");
        expect_line_idle(100);

        random_bytes(3, bytes);
        send_packet(bytes, -1);
        for (i = 0; i < 3; i++) begin
            rng_state = xorshift(rng_state);
            random_bytes(1 + rng_state % 5, bytes);
            send_packet(bytes, -1);
        end
        random_bytes(8, bytes);
        send_packet(bytes, -1); // Three bytes overflow the buffer.

        random_bytes(3, bytes);
        @(posedge clk);
        tx_data <= tx_word(8'd1, bytes);
        expect_tx_bytes(bytes, 0, 2, "frame 1");
        expect_line_idle(3 * bit_cycles);
        expected_ack = 8'd1;
        random_bytes(2, bytes);
        send_packet(bytes, -1);

        random_bytes(3, frame2);
        random_bytes(2, frame3);
        @(posedge clk);
        tx_data <= tx_word(8'd2, frame2);
        expect_tx_bytes(frame2, 0, 0, "frame 2");
        @(posedge clk);
        tx_data <= tx_word(8'd3, frame3); // Frame 2 is still on the line.
        expect_tx_bytes(frame2, 1, 2, "frame 2");
        expect_tx_bytes(frame3, 0, 1, "frame 3");
        expect_line_idle(3 * bit_cycles);
        expected_ack = 8'd3;
        random_bytes(4, bytes);
        send_packet(bytes, -1);

        random_bytes(4, bytes);
        send_packet(bytes, 1);

        $display("Testbench passed");
        $finish;
    end

endmodule

/* sim.f */
+incdir+bench
source/uart_pkg.sv
source/frame_pkg.sv
source/rx_byte_if.sv
source/uart_rx.sv
source/uart_tx.sv
source/rx_frame_assembler.sv
source/tx_frame_sender.sv
source/uart_bridge.sv
bench/tb_uart_bridge.sv

/* source/frame_pkg.sv */
package frame_pkg;

    typedef logic [7:0] frame_id_t; // Wraps modulo 256.
    typedef logic [7:0] frame_len_t;

    // Receive word layout.
    localparam int rx_ack_lsb     = 0;
    localparam int rx_count_lsb   = 8;  // Frame counter.
    localparam int rx_len_lsb     = 16; // Byte count.
    localparam int rx_payload_lsb = 24; // First byte lowest.

    // Transmit word layout.
    localparam int tx_id_lsb      = 0;
    localparam int tx_len_lsb     = 8;  // Number of bytes minus one.
    localparam int tx_payload_lsb = 16;

endpackage

/* source/rx_byte_if.sv */
`timescale 1ns/100ps

interface rx_byte_if;
    import uart_pkg::*;

    uart_byte_t data;
    logic       valid;         // One cycle per good byte.
    logic       idle;          // Line quiet for idle_bits.
    logic       end_of_packet; // First idle after at least one byte.

    modport source (
        output data,
        output valid,
        output idle,
        output end_of_packet
    );

    modport sink (
        input data,
        input valid,
        input idle,
        input end_of_packet
    );

endinterface

/* source/rx_frame_assembler.sv */
`timescale 1ns/100ps

module rx_frame_assembler #(
    parameter int rx_buffer_bits = 64
) (
    input  logic                     clk,
    input  logic                     rst,
    rx_byte_if.sink                  bytes,
    input  frame_pkg::frame_id_t     ack_id,
    output logic [rx_buffer_bits-1:0] rx_data
);
    import frame_pkg::*;

    localparam int payload_bits = rx_buffer_bits - rx_payload_lsb;
    localparam frame_len_t capacity = frame_len_t'(rx_buffer_bits / 8 - 3);

    logic [payload_bits-1:0] buffer;
    frame_len_t              count;
    frame_id_t               frame_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            buffer    <= '0;
            count     <= '0;
            frame_cnt <= '0;
            rx_data   <= '0;
        end else if (bytes.end_of_packet) begin
            rx_data[rx_ack_lsb +: 8]                 <= ack_id;
            rx_data[rx_count_lsb +: 8]               <= frame_cnt;
            rx_data[rx_len_lsb +: 8]                 <= count;
            rx_data[rx_payload_lsb +: payload_bits]  <= buffer;
            frame_cnt <= frame_cnt + frame_id_t'(1);
            buffer    <= '0;
            count     <= '0;
        end else if (bytes.valid && count < capacity) begin
            // Bytes past the capacity are lost and not counted.
            buffer[int'(count) * 8 +: 8] <= bytes.data;
            count <= count + frame_len_t'(1);
        end
    end

endmodule

/* source/tx_frame_sender.sv */
`timescale 1ns/100ps

module tx_frame_sender #(
    parameter int tx_buffer_bits = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [tx_buffer_bits-1:0] tx_data,
    output uart_pkg::uart_byte_t      tx_byte,
    output logic                      start,
    input  logic                      busy,
    output frame_pkg::frame_id_t      ack_id
);
    import uart_pkg::*;
    import frame_pkg::*;

    localparam int payload_bits = tx_buffer_bits - tx_payload_lsb;
    localparam frame_len_t max_len = frame_len_t'(tx_buffer_bits / 8 - 3);

    typedef enum logic [1:0] {st_idle, st_load, st_wait_busy, st_done} state_t;

    state_t                  state;
    frame_id_t               last_id;
    frame_id_t               new_id;
    frame_len_t              new_len;
    frame_len_t              remaining; // Bytes still to go after the current one.
    logic [payload_bits-1:0] payload;

    assign new_id  = tx_data[tx_id_lsb +: 8];
    assign new_len = tx_data[tx_len_lsb +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            last_id <= '0;
            ack_id  <= '0;
            start   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    start <= 1'b0;
                    if (new_id != last_id) begin
                        last_id   <= new_id;
                        payload   <= tx_data[tx_payload_lsb +: payload_bits];
                        remaining <= (new_len > max_len) ? max_len : new_len;
                        state     <= st_load;
                    end
                end
                st_load: begin
                    if (!busy) begin
                        tx_byte <= uart_byte_t'(payload[7:0]);
                        payload <= payload >> 8;
                        start   <= 1'b1;
                        state   <= st_wait_busy;
                    end
                end
                st_wait_busy: begin
                    start <= 1'b0;
                    if (busy)
                        state <= st_done;
                end
                st_done: begin
                    if (!busy) begin
                        if (remaining == '0) begin
                            ack_id <= last_id; // Frame fully on the line.
                            state  <= st_idle;
                        end else begin
                            remaining <= remaining - frame_len_t'(1);
                            state     <= st_load;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* source/uart_bridge.sv */
`timescale 1ns/100ps

module uart_bridge #(
    parameter int clk_frequency  = 25_000_000,
    parameter int baud           = 3_125_000,
    parameter int rx_buffer_bits = 64,
    parameter int tx_buffer_bits = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rx,
    output logic                      tx,
    output logic [rx_buffer_bits-1:0] rx_data,
    input  logic [tx_buffer_bits-1:0] tx_data
);
    import uart_pkg::*;
    import frame_pkg::*;

    uart_byte_t tx_byte;
    logic       tx_start;
    logic       tx_busy;
    frame_id_t  ack_id;

    rx_byte_if rx_bytes ();

    uart_rx #(
        .clk_frequency (clk_frequency),
        .baud          (baud)
    ) u_uart_rx (
        .clk   (clk),
        .rst   (rst),
        .rx    (rx),
        .bytes (rx_bytes.source)
    );

    rx_frame_assembler #(
        .rx_buffer_bits (rx_buffer_bits)
    ) u_rx_frame_assembler (
        .clk     (clk),
        .rst     (rst),
        .bytes   (rx_bytes.sink),
        .ack_id  (ack_id),
        .rx_data (rx_data)
    );

    tx_frame_sender #(
        .tx_buffer_bits (tx_buffer_bits)
    ) u_tx_frame_sender (
        .clk     (clk),
        .rst     (rst),
        .tx_data (tx_data),
        .tx_byte (tx_byte),
        .start   (tx_start),
        .busy    (tx_busy),
        .ack_id  (ack_id)
    );

    uart_tx #(
        .clk_frequency (clk_frequency),
        .baud          (baud)
    ) u_uart_tx (
        .clk     (clk),
        .rst     (rst),
        .tx_byte (tx_byte),
        .start   (tx_start),
        .busy    (tx_busy),
        .tx      (tx)
    );

endmodule

/* source/uart_pkg.sv */
package uart_pkg;

    // One data byte as it travels on the serial line.
    typedef logic [7:0] uart_byte_t;

    // Counts clock cycles inside one bit period.
    typedef logic [15:0] bit_count_t;

    // Quiet bit periods on rx that close a packet.
    localparam int idle_bits = 16;

endpackage

/* source/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx #(
    parameter int clk_frequency = 25_000_000,
    parameter int baud          = 3_125_000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    rx_byte_if.source  bytes
);
    import uart_pkg::*;

    localparam bit_count_t bit_clocks = bit_count_t'(clk_frequency / baud);
    localparam bit_count_t bit_last   = bit_clocks - bit_count_t'(1);
    localparam bit_count_t half_last  = (bit_clocks >> 1) - bit_count_t'(1);

    localparam int idle_clocks = idle_bits * (clk_frequency / baud);
    localparam int idle_width  = $clog2(idle_clocks + 1);
    localparam logic [idle_width-1:0] idle_last = idle_width'(idle_clocks - 1);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

    state_t     state;
    bit_count_t cnt;
    logic [2:0] bit_idx;
    uart_byte_t shift;
    logic       rx_meta;
    logic       rx_s;
    logic       pending; // A byte arrived since the last end of packet.

    logic [idle_width-1:0] idle_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            cnt         <= '0;
            bit_idx     <= '0;
            bytes.valid <= 1'b0;
        end else begin
            bytes.valid <= 1'b0;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (!rx_s)
                        state <= st_start;
                end
                st_start: begin
                    if (cnt == half_last) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? st_idle : st_data; // Glitch, not a start bit.
                    end else begin
                        cnt <= cnt + bit_count_t'(1);
                    end
                end
                st_data: begin
                    if (cnt == bit_last) begin
                        cnt     <= '0;
                        shift   <= {rx_s, shift[7:1]}; // LSB arrives first.
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                            state <= st_stop;
                    end else begin
                        cnt <= cnt + bit_count_t'(1);
                    end
                end
                st_stop: begin
                    if (cnt == bit_last) begin
                        cnt   <= '0;
                        state <= st_idle;
                        if (rx_s) begin
                            bytes.data  <= shift;
                            bytes.valid <= 1'b1;
                        end
                    end else begin
                        cnt <= cnt + bit_count_t'(1);
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // The idle timer runs only while the receiver rests and the line is high.
    always_ff @(posedge clk) begin
        if (rst) begin
            idle_cnt            <= '0;
            pending             <= 1'b0;
            bytes.idle          <= 1'b0;
            bytes.end_of_packet <= 1'b0;
        end else begin
            bytes.end_of_packet <= 1'b0;
            if (state == st_stop && cnt == bit_last && rx_s)
                pending <= 1'b1;
            if (state != st_idle || !rx_s) begin
                idle_cnt   <= '0;
                bytes.idle <= 1'b0;
            end else if (idle_cnt == idle_last) begin
                bytes.idle <= 1'b1;
                if (!bytes.idle && pending) begin
                    bytes.end_of_packet <= 1'b1;
                    pending             <= 1'b0;
                end
            end else begin
                idle_cnt <= idle_cnt + idle_width'(1);
            end
        end
    end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx #(
    parameter int clk_frequency = 25_000_000,
    parameter int baud          = 3_125_000
) (
    input  logic                clk,
    input  logic                rst,
    input  uart_pkg::uart_byte_t tx_byte,
    input  logic                start,
    output logic                busy,
    output logic                tx
);
    import uart_pkg::*;

    localparam bit_count_t bit_last = bit_count_t'(clk_frequency / baud) - bit_count_t'(1);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

    state_t     state;
    bit_count_t cnt;
    logic [2:0] bit_idx;
    uart_byte_t shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            cnt     <= '0;
            bit_idx <= '0;
            busy    <= 1'b0;
            tx      <= 1'b1;
        end else begin
            if (state != st_idle)
                cnt <= (cnt == bit_last) ? '0 : cnt + bit_count_t'(1);
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (start) begin
                        shift <= tx_byte;
                        busy  <= 1'b1;
                        tx    <= 1'b0; // Start bit.
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (cnt == bit_last) begin
                        tx      <= shift[0];
                        shift   <= shift >> 1;
                        bit_idx <= '0;
                        state   <= st_data;
                    end
                end
                st_data: begin
                    if (cnt == bit_last) begin
                        if (bit_idx == 3'd7) begin
                            tx    <= 1'b1; // Stop bit.
                            state <= st_stop;
                        end else begin
                            tx      <= shift[0];
                            shift   <= shift >> 1;
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                st_stop: begin
                    if (cnt == bit_last) begin
                        busy  <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule
